// ==== Bender.yml ====
package:
  name: lc4_processor

sources:
  - files:
      - verilog/lc4_isa_pkg.sv
      - verilog/lc4_pipe_pkg.sv
      - verilog/lc4_decoder.sv
      - verilog/lc4_regfile.sv
      - verilog/lc4_alu.sv
      - verilog/lc4_hazard_unit.sv
      - verilog/lc4_stage_reg.sv
      - verilog/lc4_fetch.sv
      - verilog/lc4_branch_unit.sv
      - verilog/lc4_processor.sv
  - target: test
    files:
      - test/lc4_processor_tb.sv

// ==== flist.f ====
verilog/lc4_isa_pkg.sv
verilog/lc4_pipe_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_stage_reg.sv
verilog/lc4_fetch.sv
verilog/lc4_branch_unit.sv
verilog/lc4_processor.sv
test/lc4_processor_tb.sv

// ==== test/lc4_processor_tb.sv ====
// testbench for the pipelined LC4 core
// each table row is one program that ends in a store, the first store is checked
// imem covers 16 words from RESET_PC, everything else reads as NOP
// dmem covers 1024 words, never written, filled once from the LFSR
`timescale 1ns/1ns
`default_nettype none

module lc4_processor_tb;
   import lc4_isa_pkg::*;

   localparam word_t RESET_PC       = 16'h8200;
   localparam int    PROG_LEN       = 12;
   localparam int    NUM_ROWS       = 6;
   localparam int    DMEM_WORDS     = 1024;
   localparam int    TIMEOUT_CYCLES = NUM_ROWS * 40;

   // one program with the store it must produce
   typedef struct packed {
      word_t [PROG_LEN-1:0] insn;
      word_t                st_addr;
      word_t                st_data;
   } row_t;

   logic  gwe;
   logic  i_rst;
   word_t imem_data;
   word_t dmem_rdata;
   word_t imem_addr;
   word_t dmem_addr;
   word_t dmem_wdata;
   logic  dmem_we;

   word_t imem [16];
   word_t dmem [DMEM_WORDS];
   word_t imem_off;
   row_t  rows [NUM_ROWS];
   word_t prog_q [$];
   int    cycles = 0;

   lc4_processor #(.RESET_PC(RESET_PC)) DUT (
      .gwe(gwe), .i_rst(i_rst), .i_imem_data(imem_data), .i_dmem_rdata(dmem_rdata),
      .o_imem_addr(imem_addr), .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
      .o_dmem_we(dmem_we)
   );

   // 4 ns period
   initial begin
      gwe = 1'b0;
      forever #2 gwe = ~gwe;
   end

   // both memories answer in the same cycle
   assign imem_off   = imem_addr - RESET_PC;
   assign imem_data  = (imem_off < 16) ? imem[imem_off[3:0]] : NOP_WORD;
   assign dmem_rdata = (dmem_addr < DMEM_WORDS) ? dmem[dmem_addr[9:0]] : 16'h0000;

   // instruction encoders, fields as in the ISA
   function automatic word_t enc_const(input int rd, input int imm);
      return {4'b1001, rd[2:0], imm[8:0]};
   endfunction

   function automatic word_t enc_addi(input int rd, input int rs, input int imm);
      return {4'b0001, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
   endfunction

   // register forms: ADD sub 000, SUB sub 010, AND opcode 0101 sub 000
   function automatic word_t enc_rrr(input logic [3:0] opc, input logic [2:0] sub,
                                     input int rd, input int rs, input int rt);
      return {opc, rd[2:0], rs[2:0], sub, rt[2:0]};
   endfunction

   function automatic word_t enc_ldr(input int rd, input int rs, input int off);
      return {4'b0110, rd[2:0], rs[2:0], off[5:0]};
   endfunction

   // data register sits in bits 11:9
   function automatic word_t enc_str(input int rt, input int rs, input int off);
      return {4'b0111, rt[2:0], rs[2:0], off[5:0]};
   endfunction

   function automatic word_t enc_br(input logic [2:0] nzp, input int off);
      return {4'b0000, nzp, off[8:0]};
   endfunction

   // fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic fill_dmem();
      logic [31:0] s;
      word_t       w;
      s = 32'h2c77;
      for (int i = 0; i < DMEM_WORDS; i++) begin
         w = '0;
         // one step per bit taken
         for (int b = 0; b < 16; b++) begin
            s = lfsr_next(s);
            w = {w[14:0], s[0]};
         end
         dmem[i] = w;
      end
   endtask

   // moves prog_q into a row, padded with NOPs
   task automatic store_row(input int r, input word_t addr, input word_t data);
      for (int i = 0; i < PROG_LEN; i++) begin
         rows[r].insn[i] = (i < prog_q.size()) ? prog_q[i] : NOP_WORD;
      end
      rows[r].st_addr = addr;
      rows[r].st_data = data;
      prog_q.delete();
   endtask

   task automatic build_table();
      word_t r1;
      word_t r2;
      word_t r3;
      word_t r4;
      word_t r5;
      // dependent chain, M and W bypasses on every step
      r1 = word_t'(-7);
      r2 = r1 + 16'd5;
      r3 = r2 + r1;
      r4 = r3 - r2;
      r5 = r4 & r3;
      prog_q = {enc_const(1, -7), enc_addi(2, 1, 5), enc_rrr(4'b0001, 3'b000, 3, 2, 1),
                enc_rrr(4'b0001, 3'b010, 4, 3, 2), enc_rrr(4'b0101, 3'b000, 5, 4, 3),
                enc_const(6, 40), enc_str(5, 6, 2)};
      store_row(0, 16'd42, r5);
      // load used right away, one stall
      prog_q = {enc_const(1, 20), enc_ldr(2, 1, 3), enc_addi(3, 2, 5), enc_str(3, 1, 10)};
      store_row(1, 16'd30, dmem[23] + 16'd5);
      // loaded register stored next, W to M path
      prog_q = {enc_const(1, 50), enc_ldr(2, 1, -2), enc_str(2, 1, 7)};
      store_row(2, 16'd57, dmem[48]);
      // BRz taken on zero, skips two stores
      prog_q = {enc_const(2, 9), enc_const(1, 0), enc_br(3'b010, 2),
                enc_str(2, 1, 1), enc_str(1, 1, 2), enc_str(2, 1, 3)};
      store_row(3, 16'd3, 16'd9);
      // BRn not taken on a positive value
      prog_q = {enc_const(1, 12), enc_br(3'b100, 1), enc_str(1, 1, 4), enc_str(1, 1, 5)};
      store_row(4, 16'd16, 16'd12);
      // plain NOP, BR without conditions, dropped opcodes (TRAP, JMP, DIV)
      prog_q = {16'h0000, 16'h0123, 16'hF025, 16'hC1C0, 16'h1018, 16'h0000,
                16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, enc_str(0, 0, 21)};
      store_row(5, 16'd21, 16'd0);
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
         $display("TEST FAILED");
         $fatal(1, "stopping on first mismatch");
      end
   endtask

   task automatic run_row(input int r);
      @(posedge gwe);
      i_rst <= 1'b1;
      for (int i = 0; i < 16; i++) begin
         imem[i] = (i < PROG_LEN) ? rows[r].insn[i] : NOP_WORD;
      end
      repeat (4) @(posedge gwe);
      i_rst <= 1'b0;
      // first three fetches are sequential in every program
      for (int k = 0; k < 3; k++) begin
         @(negedge gwe);
         check_value("o_dmem_we", {15'd0, dmem_we}, 16'd0);
         check_value("o_imem_addr", imem_addr, RESET_PC + word_t'(k));
      end
      @(negedge gwe);
      while (dmem_we !== 1'b1) begin
         @(negedge gwe);
      end
      check_value("o_dmem_addr", dmem_addr, rows[r].st_addr);
      check_value("o_dmem_wdata", dmem_wdata, rows[r].st_data);
      $display("row %0d: store %h to %h", r, dmem_wdata, dmem_addr);
   endtask

   // run limit
   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, expected store never appeared", cycles);
         $display("TEST FAILED");
         $fatal(1, "run limit reached");
      end
   end

   initial begin
      i_rst = 1'b1;
      for (int i = 0; i < 16; i++) begin
         imem[i] = NOP_WORD;
      end
      fill_dmem();
      build_table();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_alu.sv ====
// execute-stage arithmetic, immediates, memory address and branch target
// immediates are taken straight from the instruction word
`timescale 1ns/1ns
`default_nettype none

module lc4_alu (
   input  lc4_isa_pkg::word_t    i_insn,
   input  lc4_isa_pkg::word_t    i_pc,
   input  lc4_isa_pkg::word_t    i_a,
   input  lc4_isa_pkg::word_t    i_b,
   input  lc4_pipe_pkg::alu_op_t i_op,
   output lc4_isa_pkg::word_t    o_result
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   word_t imm5;
   word_t imm6;
   word_t imm9;

   // sign extension of the three immediate widths
   assign imm5 = {{(16 - IMM5_W){i_insn[IMM5_W-1]}}, i_insn[IMM5_W-1:0]};
   assign imm6 = {{(16 - IMM6_W){i_insn[IMM6_W-1]}}, i_insn[IMM6_W-1:0]};
   assign imm9 = {{(16 - IMM9_W){i_insn[IMM9_W-1]}}, i_insn[IMM9_W-1:0]};

   always_comb begin
      case (i_op)
         ALU_ADD:      o_result = i_a + i_b;
         ALU_SUB:      o_result = i_a - i_b;
         ALU_AND:      o_result = i_a & i_b;
         ALU_ADDI:     o_result = i_a + imm5;
         ALU_CONST:    o_result = imm9;
         // base register plus offset, for LDR and STR
         ALU_MEMADDR:  o_result = i_a + imm6;
         // target relative to the next PC
         ALU_BRTARGET: o_result = i_pc + 16'd1 + imm9;
         default:      o_result = i_a;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_branch_unit.sv ====
// NZP register and branch decision in X
// NZP is 000 after reset, so no branch is taken until it is set
`timescale 1ns/1ns
`default_nettype none

module lc4_branch_unit (
   input  wire                 gwe,
   input  wire                 i_rst,
   input  lc4_pipe_pkg::ctrl_t i_x_ctrl,
   input  lc4_isa_pkg::nzp_t   i_x_cond,
   input  wire                 i_m_nzp_we,
   input  lc4_isa_pkg::word_t  i_m_value,
   output logic                o_taken
);
   import lc4_isa_pkg::*;

   nzp_t nzp_q;
   nzp_t nzp_new;
   nzp_t nzp_cur;

   // sign of the M-stage final value
   always_comb begin
      if (i_m_value[15]) begin
         nzp_new = 3'b100;
      end else if (i_m_value == '0) begin
         nzp_new = 3'b010;
      end else begin
         nzp_new = 3'b001;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         nzp_q <= 3'b000;
      end else if (i_m_nzp_we) begin
         nzp_q <= nzp_new;
      end
   end

   // newest value bypassed from M
   assign nzp_cur = i_m_nzp_we ? nzp_new : nzp_q;

   assign o_taken = i_x_ctrl.is_branch && |(i_x_cond & nzp_cur);

endmodule

`default_nettype wire

// ==== verilog/lc4_decoder.sv ====
// instruction decoder, purely combinational
// opcodes and sub-ops outside the kept subset decode to bubble control
`timescale 1ns/1ns
`default_nettype none

module lc4_decoder (
   input  lc4_isa_pkg::word_t    i_insn,
   output lc4_pipe_pkg::ctrl_t   o_ctrl,
   output lc4_isa_pkg::reg_sel_t o_rs,
   output lc4_isa_pkg::reg_sel_t o_rt,
   output lc4_isa_pkg::reg_sel_t o_rd
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   opcode_t    opc;
   logic [2:0] sub_op;

   assign opc    = opcode_t'(i_insn[OPC_HI:OPC_LO]);
   assign sub_op = i_insn[SUB_HI:SUB_LO];

   assign o_rs = i_insn[RS_HI:RS_LO];
   assign o_rd = i_insn[RD_HI:RD_LO];
   // store data comes from the rd field
   assign o_rt = (opc == OP_STR) ? i_insn[RD_HI:RD_LO] : i_insn[RT_HI:RT_LO];

   always_comb begin
      o_ctrl = CTRL_BUBBLE;
      case (opc)
         OP_BR: begin
            // BR with nzp 000 is the NOP
            if (i_insn[RD_HI:RD_LO] != 3'b000) begin
               o_ctrl.is_branch = 1'b1;
               o_ctrl.alu_op    = ALU_BRTARGET;
            end
         end
         OP_ARITH: begin
            if (i_insn[IMM_SEL_BIT]) begin
               o_ctrl = '{rs_re: 1'b1, rt_re: 1'b0, rd_we: 1'b1, nzp_we: 1'b1,
                          is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0,
                          alu_op: ALU_ADDI};
            end else if (sub_op == SUB_ADD || sub_op == SUB_SUB) begin
               o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, rd_we: 1'b1, nzp_we: 1'b1,
                          is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0,
                          alu_op: (sub_op == SUB_ADD) ? ALU_ADD : ALU_SUB};
            end
         end
         OP_AND: begin
            // only the register form, the rest is NOP
            if (sub_op == SUB_AND) begin
               o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, rd_we: 1'b1, nzp_we: 1'b1,
                          is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0,
                          alu_op: ALU_AND};
            end
         end
         OP_LDR: begin
            o_ctrl = '{rs_re: 1'b1, rt_re: 1'b0, rd_we: 1'b1, nzp_we: 1'b1,
                       is_load: 1'b1, is_store: 1'b0, is_branch: 1'b0,
                       alu_op: ALU_MEMADDR};
         end
         OP_STR: begin
            o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, rd_we: 1'b0, nzp_we: 1'b0,
                       is_load: 1'b0, is_store: 1'b1, is_branch: 1'b0,
                       alu_op: ALU_MEMADDR};
         end
         OP_CONST: begin
            o_ctrl.rd_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_CONST;
         end
         default: o_ctrl = CTRL_BUBBLE;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/lc4_fetch.sv ====
// program counter for the fetch stage
// taken wins over stall, the PC steps by one otherwise
`timescale 1ns/1ns
`default_nettype none

module lc4_fetch #(
   parameter lc4_isa_pkg::word_t RESET_PC = 16'h8200
) (
   input  wire                gwe,
   input  wire                i_rst,
   input  wire                i_stall,
   input  wire                i_taken,
   input  lc4_isa_pkg::word_t i_target,
   output lc4_isa_pkg::word_t o_pc
);
   import lc4_isa_pkg::*;

   word_t pc;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc <= RESET_PC;
      end else if (i_taken) begin
         pc <= i_target;
      end else if (!i_stall) begin
         pc <= pc + 16'd1;
      end
   end

   assign o_pc = pc;

   // a load and a branch never share X, so stall and taken are exclusive
   a_taken_target : assert property (@(posedge gwe) disable iff (i_rst)
      i_taken |-> !i_stall && !$isunknown(i_target));

endmodule

`default_nettype wire

// ==== verilog/lc4_hazard_unit.sv ====
// load-use stall and bypass selects
// M wins over W when both write the same register
// a store's data register never stalls, the W to M path covers it
`timescale 1ns/1ns
`default_nettype none

module lc4_hazard_unit (
   input  lc4_isa_pkg::reg_sel_t  i_d_rs,
   input  lc4_isa_pkg::reg_sel_t  i_d_rt,
   input  lc4_pipe_pkg::ctrl_t    i_d_ctrl,
   input  lc4_pipe_pkg::dx_t      i_x,
   input  lc4_pipe_pkg::xm_t      i_m,
   input  lc4_pipe_pkg::mw_t      i_w,
   output logic                   o_stall,
   output lc4_pipe_pkg::fwd_sel_t o_fwd_a,
   output lc4_pipe_pkg::fwd_sel_t o_fwd_b,
   output logic                   o_fwd_store
);
   import lc4_pipe_pkg::*;

   logic use_rs;
   logic use_rt;

   // D reads the load target right away
   assign use_rs  = i_d_ctrl.rs_re && (i_d_rs == i_x.rd);
   assign use_rt  = i_d_ctrl.rt_re && !i_d_ctrl.is_store && (i_d_rt == i_x.rd);
   assign o_stall = i_x.ctrl.is_load && i_x.ctrl.rd_we && (use_rs || use_rt);

   always_comb begin
      o_fwd_a = FWD_REG;
      if (i_x.ctrl.rs_re) begin
         if (i_m.ctrl.rd_we && i_m.rd == i_x.rs) begin
            o_fwd_a = FWD_M;
         end else if (i_w.ctrl.rd_we && i_w.rd == i_x.rs) begin
            o_fwd_a = FWD_W;
         end
      end
   end

   always_comb begin
      o_fwd_b = FWD_REG;
      if (i_x.ctrl.rt_re) begin
         if (i_m.ctrl.rd_we && i_m.rd == i_x.rt) begin
            o_fwd_b = FWD_M;
         end else if (i_w.ctrl.rd_we && i_w.rd == i_x.rt) begin
            o_fwd_b = FWD_W;
         end
      end
   end

   // store data in M taken from the value W is writing
   assign o_fwd_store = i_m.ctrl.is_store && i_w.ctrl.rd_we && (i_w.rd == i_m.rt);

endmodule

`default_nettype wire

// ==== verilog/lc4_isa_pkg.sv ====
// LC4 instruction encoding for the reduced core
// only the opcodes listed in opcode_t are executed, all others run as NOP
// STR carries its data register in the rd field, bits 11:9
`default_nettype none

package lc4_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;

   // condition bits, N high, Z middle, P low
   typedef logic [2:0]  nzp_t;

   // opcode field values of the kept instructions
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_AND   = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_t;

   // field positions
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_HI  = 11;
   localparam int RD_LO  = 9;
   localparam int RS_HI  = 8;
   localparam int RS_LO  = 6;
   localparam int RT_HI  = 2;
   localparam int RT_LO  = 0;
   localparam int SUB_HI = 5;
   localparam int SUB_LO = 3;

   // bit 5 set on ARITH means ADD with imm5
   localparam int IMM_SEL_BIT = 5;

   // immediate widths
   localparam int IMM5_W = 5;
   localparam int IMM6_W = 6;
   localparam int IMM9_W = 9;

   // sub-op codes in bits 5:3
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;

   // BR with no condition bits, used as the bubble
   localparam word_t NOP_WORD = 16'h0000;

endpackage

`default_nettype wire

// ==== verilog/lc4_pipe_pkg.sv ====
// pipeline control and stage payload types
// every BUBBLE constant has all control bits clear, so it never writes state
`default_nettype none

package lc4_pipe_pkg;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_ADDI,
      ALU_CONST, ALU_MEMADDR, ALU_BRTARGET, ALU_PASS
   } alu_op_t;

   // operand source in X
   typedef enum logic [1:0] {FWD_REG, FWD_M, FWD_W} fwd_sel_t;

   typedef struct packed {
      logic    rs_re;
      logic    rt_re;
      logic    rd_we;
      logic    nzp_we;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      alu_op_t alu_op;
   } ctrl_t;

   typedef struct packed {
      lc4_isa_pkg::word_t pc;
      lc4_isa_pkg::word_t insn;
   } fd_t;

   typedef struct packed {
      lc4_isa_pkg::word_t    pc;
      lc4_isa_pkg::word_t    insn;
      ctrl_t                 ctrl;
      lc4_isa_pkg::reg_sel_t rs;
      lc4_isa_pkg::reg_sel_t rt;
      lc4_isa_pkg::reg_sel_t rd;
      lc4_isa_pkg::word_t    rs_data;
      lc4_isa_pkg::word_t    rt_data;
   } dx_t;

   typedef struct packed {
      lc4_isa_pkg::word_t    result;
      lc4_isa_pkg::word_t    store_data;
      lc4_isa_pkg::reg_sel_t rt;
      lc4_isa_pkg::reg_sel_t rd;
      ctrl_t                 ctrl;
   } xm_t;

   typedef struct packed {
      lc4_isa_pkg::word_t    value;
      lc4_isa_pkg::reg_sel_t rd;
      ctrl_t                 ctrl;
   } mw_t;

   localparam ctrl_t CTRL_BUBBLE = '{
      rs_re: 1'b0, rt_re: 1'b0, rd_we: 1'b0, nzp_we: 1'b0,
      is_load: 1'b0, is_store: 1'b0, is_branch: 1'b0, alu_op: ALU_PASS
   };

   localparam fd_t FD_BUBBLE = '{pc: '0, insn: lc4_isa_pkg::NOP_WORD};

   localparam dx_t DX_BUBBLE = '{
      pc: '0, insn: lc4_isa_pkg::NOP_WORD, ctrl: CTRL_BUBBLE,
      rs: '0, rt: '0, rd: '0, rs_data: '0, rt_data: '0
   };

   localparam xm_t XM_BUBBLE = '{
      result: '0, store_data: '0, rt: '0, rd: '0, ctrl: CTRL_BUBBLE
   };

   localparam mw_t MW_BUBBLE = '{value: '0, rd: '0, ctrl: CTRL_BUBBLE};

endpackage

`default_nettype wire

// ==== verilog/lc4_processor.sv ====
// five-stage pipelined LC4 core, reduced instruction set
// both memories sit outside and answer in the same cycle, no wait states
// dmem address reads 0 when M holds neither a load nor a store
`timescale 1ns/1ns
`default_nettype none

module lc4_processor #(
   parameter lc4_isa_pkg::word_t RESET_PC = 16'h8200
) (
   input  wire                gwe,
   input  wire                i_rst,
   input  lc4_isa_pkg::word_t i_imem_data,
   input  lc4_isa_pkg::word_t i_dmem_rdata,
   output lc4_isa_pkg::word_t o_imem_addr,
   output lc4_isa_pkg::word_t o_dmem_addr,
   output lc4_isa_pkg::word_t o_dmem_wdata,
   output logic               o_dmem_we
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   fd_t      fd_d, fd_q;
   dx_t      dx_d, dx_q;
   xm_t      xm_d, xm_q;
   mw_t      mw_d, mw_q;
   word_t    f_pc;
   ctrl_t    d_ctrl;
   reg_sel_t d_rs, d_rt, d_rd;
   word_t    d_rs_data, d_rt_data;
   word_t    x_a, x_b, x_result;
   word_t    m_value;
   logic     stall, taken;
   fwd_sel_t fwd_a, fwd_b;
   logic     fwd_store;

   // fetch
   lc4_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .gwe(gwe), .i_rst(i_rst), .i_stall(stall), .i_taken(taken),
      .i_target(x_result), .o_pc(f_pc)
   );
   assign o_imem_addr = f_pc;
   assign fd_d        = '{pc: f_pc, insn: i_imem_data};

   // stall holds F/D, a taken branch empties it
   lc4_stage_reg #(.T(fd_t), .BUBBLE(FD_BUBBLE)) u_fd (
      .gwe(gwe), .i_rst(i_rst), .i_hold(stall), .i_squash(taken),
      .i_d(fd_d), .o_q(fd_q)
   );

   // decode
   lc4_decoder u_dec (
      .i_insn(fd_q.insn), .o_ctrl(d_ctrl), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd)
   );

   lc4_regfile u_rf (
      .gwe(gwe), .i_rst(i_rst), .i_rs(d_rs), .i_rt(d_rt),
      .i_rd(mw_q.rd), .i_we(mw_q.ctrl.rd_we), .i_wdata(mw_q.value),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   assign dx_d = '{pc: fd_q.pc, insn: fd_q.insn, ctrl: d_ctrl, rs: d_rs, rt: d_rt,
                   rd: d_rd, rs_data: d_rs_data, rt_data: d_rt_data};

   // a stalled D leaves a bubble behind it
   lc4_stage_reg #(.T(dx_t), .BUBBLE(DX_BUBBLE)) u_dx (
      .gwe(gwe), .i_rst(i_rst), .i_hold(1'b0), .i_squash(stall || taken),
      .i_d(dx_d), .o_q(dx_q)
   );

   lc4_hazard_unit u_haz (
      .i_d_rs(d_rs), .i_d_rt(d_rt), .i_d_ctrl(d_ctrl),
      .i_x(dx_q), .i_m(xm_q), .i_w(mw_q),
      .o_stall(stall), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_fwd_store(fwd_store)
   );

   // execute, operand bypass muxes
   always_comb begin
      case (fwd_a)
         FWD_M:   x_a = xm_q.result;
         FWD_W:   x_a = mw_q.value;
         default: x_a = dx_q.rs_data;
      endcase
      case (fwd_b)
         FWD_M:   x_b = xm_q.result;
         FWD_W:   x_b = mw_q.value;
         default: x_b = dx_q.rt_data;
      endcase
   end

   lc4_alu u_alu (
      .i_insn(dx_q.insn), .i_pc(dx_q.pc), .i_a(x_a), .i_b(x_b),
      .i_op(dx_q.ctrl.alu_op), .o_result(x_result)
   );

   // condition bits sit in the rd field of BR
   lc4_branch_unit u_br (
      .gwe(gwe), .i_rst(i_rst), .i_x_ctrl(dx_q.ctrl),
      .i_x_cond(nzp_t'(dx_q.insn[RD_HI:RD_LO])),
      .i_m_nzp_we(xm_q.ctrl.nzp_we), .i_m_value(m_value), .o_taken(taken)
   );

   assign xm_d = '{result: x_result, store_data: x_b, rt: dx_q.rt, rd: dx_q.rd,
                   ctrl: dx_q.ctrl};

   lc4_stage_reg #(.T(xm_t), .BUBBLE(XM_BUBBLE)) u_xm (
      .gwe(gwe), .i_rst(i_rst), .i_hold(1'b0), .i_squash(1'b0),
      .i_d(xm_d), .o_q(xm_q)
   );

   // memory
   assign o_dmem_we    = xm_q.ctrl.is_store;
   assign o_dmem_addr  = (xm_q.ctrl.is_load || xm_q.ctrl.is_store) ? xm_q.result : '0;
   // load result in W feeds a store right behind it
   assign o_dmem_wdata = fwd_store ? mw_q.value : xm_q.store_data;
   assign m_value      = xm_q.ctrl.is_load ? i_dmem_rdata : xm_q.result;

   assign mw_d = '{value: m_value, rd: xm_q.rd, ctrl: xm_q.ctrl};

   lc4_stage_reg #(.T(mw_t), .BUBBLE(MW_BUBBLE)) u_mw (
      .gwe(gwe), .i_rst(i_rst), .i_hold(1'b0), .i_squash(1'b0),
      .i_d(mw_d), .o_q(mw_q)
   );

endmodule

`default_nettype wire

// ==== verilog/lc4_regfile.sv ====
// eight 16-bit registers, two read ports, one write port
// reads of the register written in the same cycle see the new value
`timescale 1ns/1ns
`default_nettype none

module lc4_regfile (
   input  wire                   gwe,
   input  wire                   i_rst,
   input  lc4_isa_pkg::reg_sel_t i_rs,
   input  lc4_isa_pkg::reg_sel_t i_rt,
   input  lc4_isa_pkg::reg_sel_t i_rd,
   input  wire                   i_we,
   input  lc4_isa_pkg::word_t    i_wdata,
   output lc4_isa_pkg::word_t    o_rs_data,
   output lc4_isa_pkg::word_t    o_rt_data
);
   import lc4_isa_pkg::*;

   word_t regs [8];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through, W and D share the cycle
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// ==== verilog/lc4_stage_reg.sv ====
// pipeline latch for any payload type
// squash and reset load BUBBLE, hold keeps the current value
`timescale 1ns/1ns
`default_nettype none

module lc4_stage_reg #(
   parameter type T      = logic,
   parameter T    BUBBLE = '0
) (
   input  wire gwe,
   input  wire i_rst,
   input  wire i_hold,
   input  wire i_squash,
   input  T    i_d,
   output T    o_q
);

   always_ff @(posedge gwe) begin
      if (i_rst || i_squash) begin
         o_q <= BUBBLE;
      end else if (!i_hold) begin
         o_q <= i_d;
      end
   end

   // callers never hold and squash in the same cycle
   a_hold_squash : assert property (@(posedge gwe) disable iff (i_rst)
      !(i_hold && i_squash));

endmodule

`default_nettype wire
